//--- cpuPkg.sv
// ========================================================================
// Shared types for the five-stage RV32I core. Only the base 32-bit
// encodings are decoded, and memory access is whole words only.
// ========================================================================
`default_nettype none

package cpuPkg;

    localparam int xlen = 32;

    typedef logic [4:0] regIdxT;

    // One instruction word seen through each base format
    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            regIdxT     rs2;
            regIdxT     rs1;
            logic [2:0] funct3;
            regIdxT     rd;
            logic [6:0] opcode;
        } r;
        struct packed {
            logic [11:0] imm;
            regIdxT      rs1;
            logic [2:0]  funct3;
            regIdxT      rd;
            logic [6:0]  opcode;
        } i;
        struct packed {
            logic [6:0] immHi;
            regIdxT     rs2;
            regIdxT     rs1;
            logic [2:0] funct3;
            logic [4:0] immLo;
            logic [6:0] opcode;
        } s;
        struct packed {
            logic       imm12;
            logic [5:0] imm10to5;
            regIdxT     rs2;
            regIdxT     rs1;
            logic [2:0] funct3;
            logic [3:0] imm4to1;
            logic       imm11;
            logic [6:0] opcode;
        } b;
        struct packed {
            logic [19:0] imm;
            regIdxT      rd;
            logic [6:0]  opcode;
        } u;
        struct packed {
            logic       imm20;
            logic [9:0] imm10to1;
            logic       imm11;
            logic [7:0] imm19to12;
            regIdxT     rd;
            logic [6:0] opcode;
        } j;
    } instrT;

    typedef enum logic [3:0] {
        aluAdd, aluSub, aluAnd, aluOr, aluXor, aluSlt, aluSltu, aluPassB
    } aluOpT;

    typedef enum logic [2:0] {brNone, brEq, brNe, brLt, brGe} brKindT;

    typedef enum logic [1:0] {fwdReg, fwdMem, fwdWb} fwdSelT;

    // All zero is a bubble
    typedef struct packed {
        logic   regWrite;
        logic   memRead;
        logic   memWrite;
        logic   aluSrcImm;
        aluOpT  aluOp;
        brKindT branch;
        logic   jal;
        logic   jalr;
        logic   ecall;
        logic   rs1Used;
        logic   rs2Used;
    } ctrlT;

    typedef struct packed {
        logic [xlen-1:0] pc;
        instrT           instr;
    } ifIdT;

    typedef struct packed {
        ctrlT            ctrl;
        fwdSelT          fwdA;
        fwdSelT          fwdB;
        logic [xlen-1:0] pc;
        logic [xlen-1:0] rs1Val;
        logic [xlen-1:0] rs2Val;
        regIdxT          rs1;
        regIdxT          rs2;
        regIdxT          rd;
        logic [xlen-1:0] imm;
    } idExT;

    typedef struct packed {
        ctrlT            ctrl;
        regIdxT          rd;
        logic [xlen-1:0] aluResult;
        logic [xlen-1:0] storeData;
    } exMemT;

    typedef struct packed {
        logic            regWrite;
        logic            ecall;
        regIdxT          rd;
        logic [xlen-1:0] result;
        logic [xlen-1:0] a0;
        logic [xlen-1:0] a7;
    } memWbT;

    localparam logic [xlen-1:0] ledCode = 32'd34;
    localparam regIdxT a0Reg = 5'd10;
    localparam regIdxT a7Reg = 5'd17;

endpackage

`default_nettype wire

//--- decoder.sv
// ========================================================================
// Decodes the kept RV32I subset. Anything else, including a known opcode
// with an unsupported funct3, comes out as a bubble.
// ========================================================================
`timescale 1ns/1ps
`default_nettype none

module decoder (
    input  cpuPkg::instrT           instr,
    output cpuPkg::ctrlT            ctrl,
    output logic [cpuPkg::xlen-1:0] imm,
    output cpuPkg::regIdxT          rs1,
    output cpuPkg::regIdxT          rs2,
    output cpuPkg::regIdxT          rd
);
    import cpuPkg::*;

    localparam logic [6:0] opLui    = 7'b0110111;
    localparam logic [6:0] opOpImm  = 7'b0010011;
    localparam logic [6:0] opOp     = 7'b0110011;
    localparam logic [6:0] opLoad   = 7'b0000011;
    localparam logic [6:0] opStore  = 7'b0100011;
    localparam logic [6:0] opBranch = 7'b1100011;
    localparam logic [6:0] opJal    = 7'b1101111;
    localparam logic [6:0] opJalr   = 7'b1100111;
    localparam logic [6:0] opSystem = 7'b1110011;

    logic [xlen-1:0] immI, immS, immB, immU, immJ;
    logic            isOp;

    assign immI = {{20{instr.i.imm[11]}}, instr.i.imm};
    assign immS = {{20{instr.s.immHi[6]}}, instr.s.immHi, instr.s.immLo};
    assign immB = {{19{instr.b.imm12}}, instr.b.imm12, instr.b.imm11,
                   instr.b.imm10to5, instr.b.imm4to1, 1'b0};
    assign immU = {instr.u.imm, 12'b0};
    assign immJ = {{11{instr.j.imm20}}, instr.j.imm20, instr.j.imm19to12,
                   instr.j.imm11, instr.j.imm10to1, 1'b0};
    assign isOp = (instr.r.opcode == opOp);

    always_comb begin
        ctrl = '0;
        imm  = immI;
        rs1  = instr.r.rs1;
        rs2  = instr.r.rs2;
        rd   = instr.r.rd;
        case (instr.r.opcode)
            opLui: begin
                ctrl.regWrite  = 1'b1;
                ctrl.aluSrcImm = 1'b1;
                ctrl.aluOp     = aluPassB;
                imm            = immU;
            end
            opOpImm, opOp: begin
                ctrl.regWrite  = 1'b1;
                ctrl.rs1Used   = 1'b1;
                ctrl.rs2Used   = isOp;
                ctrl.aluSrcImm = !isOp;
                case (instr.r.funct3)
                    3'b000:  ctrl.aluOp = (isOp && instr.r.funct7[5]) ? aluSub : aluAdd;
                    3'b010:  ctrl.aluOp = aluSlt;
                    3'b100:  ctrl.aluOp = aluXor;
                    3'b110:  ctrl.aluOp = aluOr;
                    3'b111:  ctrl.aluOp = aluAnd;
                    3'b011:  begin
                        // sltiu is not kept
                        ctrl.aluOp = aluSltu;
                        if (!isOp) begin
                            ctrl = '0;
                        end
                    end
                    default: ctrl = '0;
                endcase
            end
            opLoad: if (instr.i.funct3 == 3'b010) begin
                ctrl.regWrite  = 1'b1;
                ctrl.memRead   = 1'b1;
                ctrl.aluSrcImm = 1'b1;
                ctrl.rs1Used   = 1'b1;
            end
            opStore: if (instr.s.funct3 == 3'b010) begin
                ctrl.memWrite  = 1'b1;
                ctrl.aluSrcImm = 1'b1;
                ctrl.rs1Used   = 1'b1;
                ctrl.rs2Used   = 1'b1;
                imm            = immS;
            end
            opBranch: begin
                imm = immB;
                case (instr.b.funct3)
                    3'b000:  ctrl.branch = brEq;
                    3'b001:  ctrl.branch = brNe;
                    3'b100:  ctrl.branch = brLt;
                    3'b101:  ctrl.branch = brGe;
                    default: ctrl.branch = brNone;
                endcase
                ctrl.rs1Used = (ctrl.branch != brNone);
                ctrl.rs2Used = ctrl.rs1Used;
            end
            opJal: begin
                ctrl.regWrite = 1'b1;
                ctrl.jal      = 1'b1;
                imm           = immJ;
            end
            opJalr: if (instr.i.funct3 == 3'b000) begin
                ctrl.regWrite  = 1'b1;
                ctrl.jalr      = 1'b1;
                ctrl.aluSrcImm = 1'b1;
                ctrl.rs1Used   = 1'b1;
            end
            opSystem: if (instr.i.funct3 == 3'b000 && instr.i.imm == '0) begin
                // a0 goes through the ALU (imm is 0), a7 rides as store data
                ctrl.ecall     = 1'b1;
                ctrl.aluSrcImm = 1'b1;
                ctrl.rs1Used   = 1'b1;
                ctrl.rs2Used   = 1'b1;
                rs1            = a0Reg;
                rs2            = a7Reg;
            end
            default: ctrl = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- regFile.sv
// ========================================================================
// 32 x 32 register file. Writes land on the falling edge so that an ID
// read in the same cycle already sees them. x0 reads as zero.
// ========================================================================
`timescale 1ns/1ps
`default_nettype none

module regFile (
    input  logic                    clk,
    input  cpuPkg::regIdxT          rs1,
    input  cpuPkg::regIdxT          rs2,
    input  cpuPkg::regIdxT          rd,
    input  logic [cpuPkg::xlen-1:0] wdata,
    input  logic                    we,
    output logic [cpuPkg::xlen-1:0] rdata1,
    output logic [cpuPkg::xlen-1:0] rdata2
);
    import cpuPkg::*;

    logic [xlen-1:0] regs [32];

    always_ff @(negedge clk) begin
        if (we && rd != '0) begin
            regs[rd] <= wdata;
        end
    end

    assign rdata1 = (rs1 == '0) ? '0 : regs[rs1];
    assign rdata2 = (rs2 == '0) ? '0 : regs[rs2];

endmodule

`default_nettype wire

//--- hazardUnit.sv
// ========================================================================
// Forwarding selects are worked out in ID and registered with the
// instruction, so "MEM" names the instruction now in EX.
// ========================================================================
`timescale 1ns/1ps
`default_nettype none

module hazardUnit (
    input  cpuPkg::regIdxT idRs1,
    input  cpuPkg::regIdxT idRs2,
    input  logic           idRs1Used,
    input  logic           idRs2Used,
    input  cpuPkg::regIdxT exRd,
    input  logic           exRegWrite,
    input  logic           exMemRead,
    input  cpuPkg::regIdxT memRd,
    input  logic           memRegWrite,
    input  cpuPkg::regIdxT wbRd,
    input  logic           wbRegWrite,
    output cpuPkg::fwdSelT fwdA,
    output cpuPkg::fwdSelT fwdB,
    output logic           stall
);
    import cpuPkg::*;

    // A WB write lands on the falling edge, before ID/EX captures the read port
    function automatic fwdSelT pickSource(regIdxT rs, logic used);
        if (!used || rs == '0) begin
            return fwdReg;
        end else if (exRegWrite && rs == exRd) begin
            return fwdMem;
        end else if (memRegWrite && rs == memRd) begin
            return fwdWb;
        end
        return fwdReg;
    endfunction

    always_comb begin
        fwdA  = pickSource(idRs1, idRs1Used);
        fwdB  = pickSource(idRs2, idRs2Used);
        stall = exMemRead && exRd != '0 &&
                ((idRs1Used && idRs1 == exRd) || (idRs2Used && idRs2 == exRd));
    end

endmodule

`default_nettype wire

//--- executeStage.sv
// ========================================================================
// EX stage. Branches compare the forwarded rs1 and rs2 values as signed
// numbers. Jumps return pc+4 as their result.
// ========================================================================
`timescale 1ns/1ps
`default_nettype none

module executeStage (
    input  cpuPkg::idExT            ex,
    input  cpuPkg::fwdSelT          fwdA,
    input  cpuPkg::fwdSelT          fwdB,
    input  logic [cpuPkg::xlen-1:0] memResult,
    input  logic [cpuPkg::xlen-1:0] wbResult,
    output logic [cpuPkg::xlen-1:0] result,
    output logic [cpuPkg::xlen-1:0] storeData,
    output logic                    taken,
    output logic [cpuPkg::xlen-1:0] target
);
    import cpuPkg::*;

    logic [xlen-1:0] opA, opB, aluB, aluOut;
    logic            branchTaken;

    function automatic logic [xlen-1:0] pickOperand(fwdSelT sel, logic [xlen-1:0] regVal,
                                                    logic [xlen-1:0] memVal,
                                                    logic [xlen-1:0] wbVal);
        case (sel)
            fwdMem:  return memVal;
            fwdWb:   return wbVal;
            default: return regVal;
        endcase
    endfunction

    assign opA       = pickOperand(fwdA, ex.rs1Val, memResult, wbResult);
    assign opB       = pickOperand(fwdB, ex.rs2Val, memResult, wbResult);
    assign aluB      = ex.ctrl.aluSrcImm ? ex.imm : opB;
    assign storeData = opB;

    always_comb begin
        case (ex.ctrl.aluOp)
            aluSub:   aluOut = opA - aluB;
            aluAnd:   aluOut = opA & aluB;
            aluOr:    aluOut = opA | aluB;
            aluXor:   aluOut = opA ^ aluB;
            aluSlt:   aluOut = {{(xlen-1){1'b0}}, $signed(opA) < $signed(aluB)};
            aluSltu:  aluOut = {{(xlen-1){1'b0}}, opA < aluB};
            aluPassB: aluOut = aluB;
            default:  aluOut = opA + aluB;
        endcase
    end

    always_comb begin
        case (ex.ctrl.branch)
            brEq:    branchTaken = (opA == opB);
            brNe:    branchTaken = (opA != opB);
            brLt:    branchTaken = ($signed(opA) < $signed(opB));
            brGe:    branchTaken = ($signed(opA) >= $signed(opB));
            default: branchTaken = 1'b0;
        endcase
    end

    assign taken  = branchTaken || ex.ctrl.jal || ex.ctrl.jalr;
    // jalr adds rs1 and imm in the ALU
    assign target = ex.ctrl.jalr ? {aluOut[xlen-1:1], 1'b0} : ex.pc + ex.imm;
    assign result = (ex.ctrl.jal || ex.ctrl.jalr) ? ex.pc + 32'd4 : aluOut;

endmodule

`default_nettype wire

//--- dataMemory.sv
// ========================================================================
// Word-addressed data RAM. The two low address bits are ignored and the
// address wraps at dataWords, which must be a power of two.
// ========================================================================
`timescale 1ns/1ps
`default_nettype none

module dataMemory #(
    parameter int dataWords = 1024
) (
    input  logic                    clk,
    input  logic                    we,
    input  logic [cpuPkg::xlen-1:0] addr,
    input  logic [cpuPkg::xlen-1:0] wdata,
    output logic [cpuPkg::xlen-1:0] rdata
);
    import cpuPkg::*;

    localparam int idxBits = $clog2(dataWords);

    logic [xlen-1:0]    mem [dataWords];
    logic [idxBits-1:0] idx;

    assign idx = addr[idxBits+1:2];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[idx] <= wdata;
        end
    end

    assign rdata = mem[idx];

    writeAddrKnown: assert property (@(posedge clk) we |-> !$isunknown(addr))
        else $error("data memory write with unknown address");

endmodule

`default_nettype wire

//--- ecallControl.sv
// ========================================================================
// ecall handling at writeback. a7 == 34 loads a0 into the LED register.
// Any other ecall freezes the pipeline until go is sampled high.
// ========================================================================
`timescale 1ns/1ps
`default_nettype none

module ecallControl (
    input  logic                    clk,
    input  logic                    rstN,
    input  logic                    wbEcall,
    input  logic [cpuPkg::xlen-1:0] a0,
    input  logic [cpuPkg::xlen-1:0] a7,
    input  logic                    go,
    output logic [cpuPkg::xlen-1:0] ledData,
    output logic                    cont
);
    import cpuPkg::*;

    logic halt, ledWrite, goSeen;

    assign halt     = wbEcall && (a7 != ledCode);
    assign ledWrite = wbEcall && (a7 == ledCode);
    assign cont     = !halt || goSeen;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            ledData <= '0;
            goSeen  <= 1'b0;
        end else begin
            if (ledWrite) begin
                ledData <= a0;
            end
            // One release cycle, then the ecall has left WB
            goSeen <= halt && go && !goSeen;
        end
    end

    releaseAfterGo: assert property (@(posedge clk) disable iff (!rstN)
        $rose(cont) |-> $past(halt && go))
        else $error("pipeline released without go during a halt");

endmodule

`default_nettype wire

//--- cpu.sv
// ========================================================================
// Five-stage RV32I pipeline. Fetch is combinational: instr must match
// instrAddr in the same cycle. dataWords must be a power of two.
// ========================================================================
`timescale 1ns/1ps
`default_nettype none

module cpu #(
    parameter int dataWords = 1024
) (
    input  logic                    clk,
    input  logic                    rstN,
    output logic [cpuPkg::xlen-1:0] instrAddr,
    input  cpuPkg::instrT           instr,
    input  logic                    go,
    output logic [cpuPkg::xlen-1:0] ledData
);
    import cpuPkg::*;

    logic [xlen-1:0] pc;
    ifIdT            ifId;
    idExT            idEx;
    exMemT           exMem;
    memWbT           memWb;

    ctrlT            idCtrl;
    logic [xlen-1:0] idImm;
    regIdxT          idRs1, idRs2, idRd;
    logic [xlen-1:0] idRs1Val, idRs2Val;
    fwdSelT          fwdA, fwdB;
    logic            stall, taken, cont;
    logic [xlen-1:0] exResult, exStoreData, target;
    logic [xlen-1:0] memRdata, memResult;

    assign instrAddr = pc;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            pc <= '0;
        end else if (cont && (taken || !stall)) begin
            pc <= taken ? target : pc + 32'd4;
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            ifId <= '0;
        end else if (cont) begin
            if (taken) begin
                ifId <= '0;
            end else if (!stall) begin
                ifId.pc    <= pc;
                ifId.instr <= instr;
            end
        end
    end

    decoder decoder_i (
        .instr(ifId.instr), .ctrl(idCtrl), .imm(idImm),
        .rs1(idRs1), .rs2(idRs2), .rd(idRd)
    );

    regFile regFile_i (
        .clk(clk), .rs1(idRs1), .rs2(idRs2),
        .rd(memWb.rd), .wdata(memWb.result), .we(memWb.regWrite),
        .rdata1(idRs1Val), .rdata2(idRs2Val)
    );

    hazardUnit hazardUnit_i (
        .idRs1(idRs1), .idRs2(idRs2),
        .idRs1Used(idCtrl.rs1Used), .idRs2Used(idCtrl.rs2Used),
        .exRd(idEx.rd), .exRegWrite(idEx.ctrl.regWrite), .exMemRead(idEx.ctrl.memRead),
        .memRd(exMem.rd), .memRegWrite(exMem.ctrl.regWrite),
        .wbRd(memWb.rd), .wbRegWrite(memWb.regWrite),
        .fwdA(fwdA), .fwdB(fwdB), .stall(stall)
    );

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            idEx <= '0;
        end else if (cont) begin
            if (taken || stall) begin
                idEx <= '0;
            end else begin
                idEx <= '{ctrl: idCtrl, fwdA: fwdA, fwdB: fwdB, pc: ifId.pc,
                          rs1Val: idRs1Val, rs2Val: idRs2Val,
                          rs1: idRs1, rs2: idRs2, rd: idRd, imm: idImm};
            end
        end
    end

    executeStage executeStage_i (
        .ex(idEx), .fwdA(idEx.fwdA), .fwdB(idEx.fwdB),
        .memResult(exMem.aluResult), .wbResult(memWb.result),
        .result(exResult), .storeData(exStoreData), .taken(taken), .target(target)
    );

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            exMem <= '0;
        end else if (cont) begin
            exMem <= '{ctrl: idEx.ctrl, rd: idEx.rd,
                       aluResult: exResult, storeData: exStoreData};
        end
    end

    // Stores wait out a halt
    dataMemory #(.dataWords(dataWords)) dataMemory_i (
        .clk(clk), .we(exMem.ctrl.memWrite && cont), .addr(exMem.aluResult),
        .wdata(exMem.storeData), .rdata(memRdata)
    );

    assign memResult = exMem.ctrl.memRead ? memRdata : exMem.aluResult;

    // For an ecall the ALU result is a0 and the store data is a7
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            memWb <= '0;
        end else if (cont) begin
            memWb <= '{regWrite: exMem.ctrl.regWrite, ecall: exMem.ctrl.ecall,
                       rd: exMem.rd, result: memResult,
                       a0: exMem.aluResult, a7: exMem.storeData};
        end
    end

    ecallControl ecallControl_i (
        .clk(clk), .rstN(rstN), .wbEcall(memWb.ecall),
        .a0(memWb.a0), .a7(memWb.a7), .go(go),
        .ledData(ledData), .cont(cont)
    );

    // A load in EX is never a branch, so the stall cannot hide a taken branch
    noStallOnTaken: assert property (@(posedge clk) disable iff (!rstN)
        !(stall && taken));

endmodule

`default_nettype wire

//--- tbClock.sv
// ============================================================================
// Testbench clock (8 ns period) and active-low reset held for 3 cycles,
// released 1 ns after a rising edge
// ============================================================================
`timescale 1ns/1ps
`default_nettype none

module tbClock (
    output logic clk,
    output logic rstN
);
    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    initial begin
        rstN = 1'b0;
        repeat (3) @(posedge clk);
        #1 rstN = 1'b1;
    end

endmodule

`default_nettype wire

//--- cpuTb.sv
// ============================================================================
// Testbench for cpu. Program words and the expected LED / halt sequence come
// from stimulus.txt in the project root. Fetch is answered combinationally,
// and addresses past the program return a nop.
// ============================================================================
`timescale 1ns/1ps
`default_nettype none

module cpuTb;
    import cpuPkg::*;

    localparam logic [31:0] nopWord  = 32'h0000_0013;
    localparam int          maxWords = 256;

    logic        clk, rstN, go;
    logic [31:0] instrAddr, ledData;
    instrT       instr;

    logic [31:0] prog [maxWords];
    int          progLen = 0;
    logic [31:0] expVal [$];
    bit          expHalt [$];
    int          cycles = 0;
    int          cycleLimit = 0;
    logic [31:0] lcgState;

    tbClock tbClock_i (.clk(clk), .rstN(rstN));

    cpu #(.dataWords(1024)) cpu_i (
        .clk(clk), .rstN(rstN), .instrAddr(instrAddr), .instr(instr),
        .go(go), .ledData(ledData)
    );

    always_comb begin
        if ((instrAddr >> 2) < progLen) begin
            instr = prog[instrAddr[9:2]];
        end else begin
            instr = nopWord;
        end
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycleLimit > 0 && cycles >= cycleLimit) begin
            $display("Timeout after %0d cycles without reaching the end of the sequence",
                     cycles);
            $display("Checks failed");
            $fatal(1, "run stopped by cycle limit");
        end
    end

    function automatic logic [31:0] lcgNext(logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic checkValue(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        if (got !== exp) begin
            $display("ERROR at %0d ns: %s is %h, expected %h", $time, name, got, exp);
            $display("Checks failed");
            $fatal(1, "first mismatch ends the run");
        end
    endtask

    // Each line holds P <word>, E <led value> or H, and '#' starts a comment line
    task automatic readStimulus();
        int          fd;
        int          n;
        string       line;
        logic [31:0] val;
        fd = $fopen("stimulus.txt", "r");
        if (fd == 0) begin
            $display("Could not open stimulus.txt");
            $display("Checks failed");
            $fatal(1, "missing stimulus file");
        end
        while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            if (line.len() > 0 && line[0] != "#") begin
                val = '0;
                if (line.len() > 2) begin
                    n = $sscanf(line.substr(2, line.len() - 1), "%h", val);
                end
                case (line[0])
                    "P": begin
                        prog[progLen] = val;
                        progLen++;
                    end
                    "E": begin
                        expVal.push_back(val);
                        expHalt.push_back(1'b0);
                    end
                    "H": begin
                        expVal.push_back('0);
                        expHalt.push_back(1'b1);
                    end
                    default: ;
                endcase
            end
        end
        $fclose(fd);
    endtask

    task automatic waitForLed(input logic [31:0] lastLed);
        do begin
            @(negedge clk);
        end while (ledData === lastLed);
    endtask

    // A load-use stall holds the PC for one cycle only, so three equal samples mean halt
    task automatic waitForHalt(input logic [31:0] lastLed, output logic [31:0] haltAddr);
        int          stable;
        logic [31:0] prevAddr;
        stable   = 0;
        prevAddr = instrAddr;
        while (stable < 2) begin
            @(negedge clk);
            checkValue("ledData", ledData, lastLed);
            if (instrAddr == prevAddr) begin
                stable++;
            end else begin
                stable = 0;
            end
            prevAddr = instrAddr;
        end
        haltAddr = instrAddr;
    endtask

    task automatic holdThroughHalt(input logic [31:0] lastLed, input logic [31:0] haltAddr);
        int holdCycles;
        lcgState   = lcgNext(lcgState);
        holdCycles = 10 + int'(lcgState[19:16]);
        repeat (holdCycles) begin
            @(negedge clk);
            checkValue("ledData", ledData, lastLed);
            checkValue("instrAddr", instrAddr, haltAddr);
        end
    endtask

    task automatic pulseGo();
        @(posedge clk);
        #1 go = 1'b1;
        @(posedge clk);
        #1 go = 1'b0;
    endtask

    initial begin
        logic [31:0] lastLed;
        logic [31:0] haltAddr;
        int          idx;
        go       = 1'b0;
        lcgState = 32'ha910_f797;
        readStimulus();
        // Halt detection and the longest halt wait fit well inside the margin
        cycleLimit = 40 * progLen + 25;
        @(posedge rstN);
        checkValue("ledData", ledData, 32'd0);
        checkValue("instrAddr", instrAddr, 32'd0);
        lastLed = '0;
        for (idx = 0; idx < expVal.size(); idx++) begin
            if (expHalt[idx]) begin
                waitForHalt(lastLed, haltAddr);
                holdThroughHalt(lastLed, haltAddr);
                pulseGo();
            end else begin
                waitForLed(lastLed);
                checkValue("ledData", ledData, expVal[idx]);
                lastLed = expVal[idx];
            end
        end
        $display("All checks passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- build.f
cpuPkg.sv
decoder.sv
regFile.sv
hazardUnit.sv
executeStage.sv
dataMemory.sv
ecallControl.sv
cpu.sv
tbClock.sv
cpuTb.sv

//--- run.sh
#!/bin/sh
# Compile and run the cpu testbench with Verilator.
# The result is read from the simulation log.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f build.f \
    --top-module cpuTb -o cpuTbSim
if [ $? -ne 0 ]; then
    echo "Verilator compile failed"
    exit 1
fi

./obj_dir/cpuTbSim > "$LOG" 2>&1
simStatus=$?
cat "$LOG"

if grep -q "Checks failed" "$LOG"; then
    echo "Simulation FAILED"
    exit 1
fi

if [ $simStatus -ne 0 ]; then
    echo "Simulation exited with status $simStatus"
    exit 1
fi

echo "Simulation passed"
exit 0

//--- stimulus.txt
# P <program word, hex> in address order; E <expected LED value, hex> in order
# H marks where the program halts and waits for go
P 02200893  addi x17,x0,34
P 00500513  addi x10,x0,5
P 00350513  addi x10,x10,3
P 00F54513  xori x10,x10,15
P 00000073  ecall -> 7
P 05500313  addi x6,x0,0x55
P 00602423  sw   x6,8(x0)
P 00802503  lw   x10,8(x0)
P 00150513  addi x10,x10,1
P 00000073  ecall -> 0x56
P 00630663  beq  x6,x6,+12
P 09900513  addi x10,x0,0x99
P 00000073  ecall (skipped)
P 00604463  blt  x0,x6,+8
P 09800513  addi x10,x0,0x98
P 00031463  bne  x6,x0,+8
P 09700513  addi x10,x0,0x97
P 01050513  addi x10,x10,0x10
P 00000073  ecall -> 0x66
P 008000EF  jal  x1,+8
P 09600513  addi x10,x0,0x96
P 00100893  addi x17,x0,1
P 00000073  ecall (halt)
P 02200893  addi x17,x0,34
P 01C08067  jalr x0,28(x1)
P 09500513  addi x10,x0,0x95
P 00000073  ecall (skipped)
P 00035463  bge  x6,x0,+8
P 09400513  addi x10,x0,0x94
P 40650533  sub  x10,x10,x6
P 00000073  ecall -> 0x11
E 00000007
E 00000056
E 00000066
H
E 00000011
